/* dnn_accel.f */
+incdir+hdl
hdl/dnn_types_pkg.sv
hdl/dnn_ctrl_pkg.sv
hdl/tile_cfg_if.sv
hdl/ctrl_regs.sv
hdl/data_fetch_ctrl.sv
hdl/tile_buffer.sv
hdl/pe_dot_array.sv
hdl/dnn_accel_top.sv
sim/mem_responder.sv
sim/tb_dnn_accel.sv

/* Bender.yml */
package:
  name: dnn_accel

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dnn_types_pkg.sv
      - hdl/dnn_ctrl_pkg.sv
      - hdl/tile_cfg_if.sv
      - hdl/ctrl_regs.sv
      - hdl/data_fetch_ctrl.sv
      - hdl/tile_buffer.sv
      - hdl/pe_dot_array.sv
      - hdl/dnn_accel_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/mem_responder.sv
      - sim/tb_dnn_accel.sv

/* sim/tb_dnn_accel.sv */
`timescale 1ns/100ps
`include "dnn_defines.svh"

module tb_dnn_accel
  import dnn_types_pkg::*;
();

  // Six jobs of 32 words, ten cycles per word worst case, doubled for register traffic
  localparam int JOBS        = 6;
  localparam int WORD_CYCLES = 10;
  localparam int CYCLE_LIMIT = JOBS * 2 * `DNN_BUF_DEPTH * WORD_CYCLES * 2 + 160;

  logic                       clk;
  logic                       reset;
  logic                       reg_wr;
  logic                       reg_rd;
  logic [`DNN_REG_ADDR_W-1:0] reg_addr;
  word_t                      reg_wdata;
  word_t                      reg_rdata;
  logic                       mem_req;
  mem_addr_t                  mem_addr;
  logic                       mem_ack;
  word_t                      mem_rdata;

  // Register check window
  logic  chk_vld;
  word_t chk_exp;
  string chk_name;
  int    err_cnt = 0;
  int    cycle_cnt = 0;

  // Expected fetch order of the running job
  logic      req_q;
  int        rise_cnt;
  int        job_rise0;
  int        job_len;
  int        addr_idx;
  mem_addr_t job_wb;
  mem_addr_t job_ib;
  mem_addr_t exp_addr;

  dnn_accel_top DUT (
    .clk       (clk),
    .reset     (reset),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  mem_responder u_mem (
    .clk       (clk),
    .reset     (reset),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  always #10 clk = ~clk;

  // Count request rises
  always @(posedge clk) begin
    if (reset) begin
      req_q    <= 1'b0;
      rise_cnt <= 0;
    end else begin
      req_q <= mem_req;
      if (mem_req && !req_q) begin
        rise_cnt <= rise_cnt + 1;
      end
    end
  end

  // Weight words first, then ifmap words
  always_comb begin
    addr_idx = rise_cnt - job_rise0;
    if (addr_idx < job_len) begin
      exp_addr = job_wb + mem_addr_t'(addr_idx);
    end else begin
      exp_addr = job_ib + mem_addr_t'(addr_idx - job_len);
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////
  reg_value: assert property (@(posedge clk) chk_vld |-> reg_rdata == chk_exp)
    else begin
      err_cnt++;
      $display("FAILED %s expected %h actual %h", chk_name, $sampled(chk_exp),
               $sampled(reg_rdata));
    end

  req_low_after_reset: assert property (@(posedge clk) $fell(reset) |-> !mem_req)
    else begin
      err_cnt++;
      $display("mem_req is high right after reset");
    end

  // Ack seen by the DUT on the edge that raised req
  req_rise_ack_low: assert property (@(posedge clk) disable iff (reset)
    $rose(mem_req) |-> !$past(mem_ack))
    else begin
      err_cnt++;
      $display("mem_req rose while mem_ack was still high");
    end

  addr_stable: assert property (@(posedge clk) disable iff (reset)
    mem_req && $past(mem_req) |-> $stable(mem_addr))
    else begin
      err_cnt++;
      $display("mem_addr changed while mem_req was high");
    end

  addr_order: assert property (@(posedge clk) disable iff (reset)
    $rose(mem_req) |-> mem_addr == exp_addr)
    else begin
      err_cnt++;
      $display("FAILED fetch_addr expected %h actual %h", $sampled(exp_addr),
               $sampled(mem_addr));
    end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic acc_t dot_ref(input mem_addr_t wb, input mem_addr_t ib, input int len);
    acc_t      sum;
    mem_addr_t wa;
    mem_addr_t ia;
    word_t     w;
    word_t     x;
    lane_t     a;
    lane_t     b;
    sum = '0;
    for (int i = 0; i < len; i++) begin
      wa = wb + mem_addr_t'(i);
      ia = ib + mem_addr_t'(i);
      w  = u_mem.mem[wa[7:0]];
      x  = u_mem.mem[ia[7:0]];
      for (int k = 0; k < `DNN_LANES; k++) begin
        a   = lane_t'(w[k*`DNN_LANE_W +: `DNN_LANE_W]);
        b   = lane_t'(x[k*`DNN_LANE_W +: `DNN_LANE_W]);
        sum = sum + acc_t'(a) * acc_t'(b);
      end
    end
    return sum;
  endfunction

  // Negative sums clamp to zero
  function automatic acc_t relu_ref(input acc_t sum);
    return (sum < 0) ? acc_t'(0) : sum;
  endfunction

  // First ifmap base giving a sum of the wanted sign
  task automatic find_ifmap(input mem_addr_t wb, input int len, input logic want_neg,
                            output mem_addr_t ib, output logic found);
    acc_t sum;
    found = 1'b0;
    ib    = '0;
    for (int b = 0; b < 256 && !found; b++) begin
      sum = dot_ref(wb, mem_addr_t'(b), len);
      if ((want_neg && sum < 0) || (!want_neg && sum > 0)) begin
        ib    = mem_addr_t'(b);
        found = 1'b1;
      end
    end
  endtask

  ////////////////////////////////////////
  // Register port tasks
  ////////////////////////////////////////
  task automatic write_reg(input logic [`DNN_REG_ADDR_W-1:0] addr, input word_t data);
    @(posedge clk);
    #1;
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge clk);
    #1;
    reg_wr = 1'b0;
  endtask

  task automatic read_reg(input logic [`DNN_REG_ADDR_W-1:0] addr, output word_t data);
    @(posedge clk);
    #1;
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(posedge clk);
    #1;
    reg_rd = 1'b0;
    data   = reg_rdata;
  endtask

  // Open the check window for one edge
  task automatic check_reg(input string name, input logic [`DNN_REG_ADDR_W-1:0] addr,
                           input word_t exp);
    word_t rd_word;
    read_reg(addr, rd_word);
    chk_name = name;
    chk_exp  = exp;
    chk_vld  = 1'b1;
    @(posedge clk);
    #1;
    chk_vld = 1'b0;
  endtask

  task automatic run_job(input string name, input mem_addr_t wb, input mem_addr_t ib,
                         input int len, input logic relu);
    write_reg(`DNN_REG_WGHT_BASE, word_t'(wb));
    write_reg(`DNN_REG_IFMAP_BASE, word_t'(ib));
    write_reg(`DNN_REG_LEN, word_t'(len));
    job_wb    = wb;
    job_ib    = ib;
    job_len   = len;
    job_rise0 = rise_cnt;
    write_reg(`DNN_REG_CTRL, {62'd0, relu, 1'b1});
    // Busy set, done cleared
    check_reg({name, "_busy"}, `DNN_REG_STATUS, 64'd1);
  endtask

  task automatic finish_job(input string name, input acc_t exp);
    word_t status;
    status = '0;
    while (!status[1]) begin
      read_reg(`DNN_REG_STATUS, status);
      // Busy stays up with done low until done rises
      poll_status: assert (status[1] || status == 64'd1)
        else begin
          err_cnt++;
          $display("FAILED %s_poll expected %h actual %h", name, 64'd1, status);
        end
    end
    check_reg({name, "_status"}, `DNN_REG_STATUS, 64'd2);
    check_reg(name, `DNN_REG_RESULT, {{(`DNN_WORD_W-`DNN_ACC_W){exp[`DNN_ACC_W-1]}}, exp});
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial begin
    mem_addr_t neg_ib;
    mem_addr_t pos_ib;
    logic      neg_ok;
    logic      pos_ok;
    clk       = 1'b0;
    reset     = 1'b1;
    reg_wr    = 1'b0;
    reg_rd    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    chk_vld   = 1'b0;
    chk_exp   = '0;
    chk_name  = "";
    job_wb    = '0;
    job_ib    = '0;
    job_len   = 0;
    job_rise0 = 0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    // Idle status and readback
    check_reg("status_after_reset", `DNN_REG_STATUS, 64'd0);
    write_reg(`DNN_REG_WGHT_BASE, 64'h0000_0000_1234_5678);
    check_reg("wght_base_rb", `DNN_REG_WGHT_BASE, 64'h0000_0000_1234_5678);
    write_reg(`DNN_REG_IFMAP_BASE, 64'h0000_0000_8765_4321);
    check_reg("ifmap_base_rb", `DNN_REG_IFMAP_BASE, 64'h0000_0000_8765_4321);
    write_reg(`DNN_REG_LEN, 64'd16);
    check_reg("len_rb", `DNN_REG_LEN, 64'd16);
    write_reg(`DNN_REG_CTRL, 64'd2);
    check_reg("relu_rb", `DNN_REG_CTRL, 64'd2);
    write_reg(`DNN_REG_CTRL, 64'd0);

    // Plain dot products
    run_job("dot_16", 32'd0, 32'd64, 16, 1'b0);
    finish_job("dot_16", dot_ref(32'd0, 32'd64, 16));
    run_job("dot_1", 32'd100, 32'd200, 1, 1'b0);
    finish_job("dot_1", dot_ref(32'd100, 32'd200, 1));

    // ReLU on both signs
    find_ifmap(32'd32, 4, 1'b1, neg_ib, neg_ok);
    find_ifmap(32'd32, 4, 1'b0, pos_ib, pos_ok);
    if (!neg_ok || !pos_ok) begin
      err_cnt++;
      $display("Memory holds no 4-word tile of the wanted sign for the ReLU tests");
    end else begin
      run_job("relu_neg", 32'd32, neg_ib, 4, 1'b1);
      finish_job("relu_neg", relu_ref(dot_ref(32'd32, neg_ib, 4)));
      run_job("relu_pos", 32'd32, pos_ib, 4, 1'b1);
      finish_job("relu_pos", relu_ref(dot_ref(32'd32, pos_ib, 4)));
    end

    // Second go and config write during a job
    run_job("busy_go", 32'd16, 32'd128, 16, 1'b0);
    write_reg(`DNN_REG_WGHT_BASE, 64'd200);
    write_reg(`DNN_REG_CTRL, 64'd3);
    check_reg("busy_wght_base", `DNN_REG_WGHT_BASE, 64'd16);
    check_reg("busy_ctrl", `DNN_REG_CTRL, 64'd0);
    check_reg("busy_status", `DNN_REG_STATUS, 64'd1);
    finish_job("busy_go", dot_ref(32'd16, 32'd128, 16));

    @(posedge clk);
    $display("Checks done, %0d errors", err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Run limit
  initial begin
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Run stopped after %0d cycles without reaching the end", CYCLE_LIMIT);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* sim/mem_responder.sv */
`timescale 1ns/100ps

module mem_responder
  import dnn_types_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      mem_req,
  input  mem_addr_t mem_addr,
  output logic      mem_ack,
  output word_t     mem_rdata
);

  // 256 words, address wraps on the low byte
  localparam int MEM_WORDS = 256;

  word_t  mem [0:MEM_WORDS-1];
  integer seed;
  int     dly;

  initial begin
    seed      = 97;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {$random(seed), $random(seed)};
    end
    forever begin
      @(posedge clk);
      if (!reset && mem_req && !mem_ack) begin
        // Zero to three idle cycles before the answer
        dly = {$random(seed)} % 4;
        repeat (dly) @(posedge clk);
        #1;
        mem_rdata = mem[mem_addr[7:0]];
        mem_ack   = 1'b1;
        // Hold ack until req is seen low
        @(posedge clk);
        while (mem_req) @(posedge clk);
        #1;
        mem_ack = 1'b0;
      end
    end
  end

endmodule

/* hdl/dnn_accel_top.sv */
`timescale 1ns/100ps

module dnn_accel_top
  import dnn_types_pkg::*;
  import dnn_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      reg_wr,
  input  logic      reg_rd,
  input  reg_addr_t reg_addr,
  input  word_t     reg_wdata,
  output word_t     reg_rdata,
  output logic      mem_req,
  output mem_addr_t mem_addr,
  input  logic      mem_ack,
  input  word_t     mem_rdata
);

  // PE to register file
  logic      pe_finish;
  acc_t      pe_result;
  // Fetch dispatch to buffers
  logic      buf_wr_wght;
  logic      buf_wr_ifmap;
  buf_addr_t buf_wr_addr;
  word_t     buf_wr_data;
  // Shared read index, both buffers in lockstep
  buf_addr_t pe_rd_addr;
  word_t     ifmap_rd_data;
  word_t     wght_rd_data;

  tile_cfg_if cfg_if ();

  ctrl_regs u_ctrl_regs (
    .clk       (clk),
    .reset     (reset),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .cfg       (cfg_if.regs),
    .pe_finish (pe_finish),
    .pe_result (pe_result)
  );

  data_fetch_ctrl u_fetch (
    .clk          (clk),
    .reset        (reset),
    .cfg          (cfg_if.fetch),
    .mem_req      (mem_req),
    .mem_addr     (mem_addr),
    .mem_ack      (mem_ack),
    .mem_rdata    (mem_rdata),
    .buf_wr_wght  (buf_wr_wght),
    .buf_wr_ifmap (buf_wr_ifmap),
    .buf_wr_addr  (buf_wr_addr),
    .buf_wr_data  (buf_wr_data)
  );

  tile_buffer ifmap_buf (
    .clk     (clk),
    .wr_en   (buf_wr_ifmap),
    .wr_addr (buf_wr_addr),
    .wr_data (buf_wr_data),
    .rd_addr (pe_rd_addr),
    .rd_data (ifmap_rd_data)
  );

  tile_buffer wght_buf (
    .clk     (clk),
    .wr_en   (buf_wr_wght),
    .wr_addr (buf_wr_addr),
    .wr_data (buf_wr_data),
    .rd_addr (pe_rd_addr),
    .rd_data (wght_rd_data)
  );

  pe_dot_array u_pe (
    .clk        (clk),
    .reset      (reset),
    .cfg        (cfg_if.pe),
    .rd_addr    (pe_rd_addr),
    .ifmap_data (ifmap_rd_data),
    .wght_data  (wght_rd_data),
    .finish     (pe_finish),
    .result     (pe_result)
  );

endmodule

/* hdl/pe_dot_array.sv */
`timescale 1ns/100ps
`include "dnn_defines.svh"

module pe_dot_array
  import dnn_types_pkg::*;
  import dnn_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  tile_cfg_if.pe    cfg,
  output buf_addr_t rd_addr,
  input  word_t     ifmap_data,
  input  word_t     wght_data,
  output logic      finish,
  output acc_t      result
);

  pe_state_t state;
  logic      issue_vld;
  logic      issue_last;
  logic      rd_vld;
  logic      rd_last;
  logic      prod_vld;
  logic      prod_last;
  logic      acc_last;
  prod_t     prod_d [`DNN_LANES];
  prod_t     prod_q [`DNN_LANES];
  acc_t      sum_l1 [`DNN_LANES/2];
  acc_t      sum_l2 [`DNN_LANES/4];
  acc_t      tree_sum;
  acc_t      acc;

  // One buffer index per cycle while running
  assign issue_vld  = (state == PE_RUN);
  assign issue_last = issue_vld && ({1'b0, rd_addr} == cfg.len - tile_len_t'(1));

  ////////////////////////////////////////
  // Issue FSM and valid pipeline
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= PE_IDLE;
      rd_addr   <= '0;
      rd_vld    <= 1'b0;
      rd_last   <= 1'b0;
      prod_vld  <= 1'b0;
      prod_last <= 1'b0;
      acc_last  <= 1'b0;
      finish    <= 1'b0;
    end else begin
      // Stage 1 buffer read, stage 2 products, stage 3 accumulate
      rd_vld    <= issue_vld;
      rd_last   <= issue_last;
      prod_vld  <= rd_vld;
      prod_last <= rd_last;
      acc_last  <= prod_last;
      finish    <= acc_last;
      case (state)
        PE_IDLE: begin
          if (cfg.fetch_done) begin
            rd_addr <= '0;
            state   <= PE_RUN;
          end
        end
        PE_RUN: begin
          if (issue_last) begin
            state <= PE_DRAIN;
          end else begin
            rd_addr <= rd_addr + 1'b1;
          end
        end
        // Wait for the final sum to land
        PE_DRAIN: begin
          if (acc_last) begin
            state <= PE_IDLE;
          end
        end
        default: state <= PE_IDLE;
      endcase
    end
  end

  // Signed lane products
  always_comb begin
    for (int i = 0; i < `DNN_LANES; i++) begin
      prod_d[i] = lane_t'(ifmap_data[i*`DNN_LANE_W +: `DNN_LANE_W])
                * lane_t'(wght_data[i*`DNN_LANE_W +: `DNN_LANE_W]);
    end
  end

  // Three-level adder tree for eight lanes
  always_comb begin
    for (int i = 0; i < `DNN_LANES/2; i++) begin
      sum_l1[i] = acc_t'(prod_q[2*i]) + acc_t'(prod_q[2*i+1]);
    end
    for (int i = 0; i < `DNN_LANES/4; i++) begin
      sum_l2[i] = sum_l1[2*i] + sum_l1[2*i+1];
    end
    tree_sum = sum_l2[0] + sum_l2[1];
  end

  ////////////////////////////////////////
  // Data pipeline
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rd_vld) begin
      prod_q <= prod_d;
    end
    // Fresh sum per job
    if (state == PE_IDLE && cfg.fetch_done) begin
      acc <= '0;
    end else if (prod_vld) begin
      acc <= acc + tree_sum;
    end
    // ReLU clamps negatives
    if (acc_last) begin
      result <= (cfg.relu_en && acc[`DNN_ACC_W-1]) ? '0 : acc;
    end
  end

endmodule

/* hdl/tile_buffer.sv */
`timescale 1ns/100ps
`include "dnn_defines.svh"

module tile_buffer
  import dnn_types_pkg::*;
(
  input  logic      clk,
  input  logic      wr_en,
  input  buf_addr_t wr_addr,
  input  word_t     wr_data,
  input  buf_addr_t rd_addr,
  output word_t     rd_data
);

  // Simple dual port, maps onto block RAM
  word_t mem [0:`DNN_BUF_DEPTH-1];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read, one cycle latency
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* hdl/data_fetch_ctrl.sv */
`timescale 1ns/100ps

module data_fetch_ctrl
  import dnn_types_pkg::*;
  import dnn_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  tile_cfg_if.fetch cfg,
  output logic      mem_req,
  output mem_addr_t mem_addr,
  input  logic      mem_ack,
  input  word_t     mem_rdata,
  output logic      buf_wr_wght,
  output logic      buf_wr_ifmap,
  output buf_addr_t buf_wr_addr,
  output word_t     buf_wr_data
);

  fetch_state_t state;
  // Low for weight region, high for ifmap region
  logic         ifmap_phase;
  buf_addr_t    word_idx;
  logic         last_word;

  // Last word of the current region
  assign last_word = ({1'b0, word_idx} == cfg.len - tile_len_t'(1));

  ////////////////////////////////////////
  // Four-phase sequencer
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= FETCH_IDLE;
      mem_req        <= 1'b0;
      ifmap_phase    <= 1'b0;
      word_idx       <= '0;
      buf_wr_wght    <= 1'b0;
      buf_wr_ifmap   <= 1'b0;
      cfg.fetch_done <= 1'b0;
    end else begin
      buf_wr_wght    <= 1'b0;
      buf_wr_ifmap   <= 1'b0;
      cfg.fetch_done <= 1'b0;
      case (state)
        FETCH_IDLE: begin
          // Ack is already low here
          if (cfg.start) begin
            ifmap_phase <= 1'b0;
            word_idx    <= '0;
            mem_req     <= 1'b1;
            state       <= FETCH_REQ;
          end
        end
        FETCH_REQ: begin
          // Capture and drop req on the same edge
          if (mem_ack) begin
            mem_req      <= 1'b0;
            buf_wr_wght  <= !ifmap_phase;
            buf_wr_ifmap <= ifmap_phase;
            state        <= (ifmap_phase && last_word) ? FETCH_DONE : FETCH_RELEASE;
          end
        end
        FETCH_RELEASE: begin
          // Next request only after ack falls
          if (!mem_ack) begin
            if (last_word) begin
              ifmap_phase <= 1'b1;
              word_idx    <= '0;
            end else begin
              word_idx <= word_idx + 1'b1;
            end
            mem_req <= 1'b1;
            state   <= FETCH_REQ;
          end
        end
        FETCH_DONE: begin
          // Pulse once, the cycle the last word is written
          cfg.fetch_done <= buf_wr_ifmap;
          if (!mem_ack) begin
            state <= FETCH_IDLE;
          end
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  // Address walk and captured word
  always_ff @(posedge clk) begin
    case (state)
      FETCH_IDLE: begin
        if (cfg.start) begin
          mem_addr <= cfg.wght_base;
        end
      end
      FETCH_REQ: begin
        if (mem_ack) begin
          buf_wr_addr <= word_idx;
          buf_wr_data <= mem_rdata;
        end
      end
      FETCH_RELEASE: begin
        // Weight region ends, jump to ifmap base
        if (!mem_ack) begin
          mem_addr <= last_word ? cfg.ifmap_base : mem_addr + 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

/* hdl/ctrl_regs.sv */
`timescale 1ns/100ps
`include "dnn_defines.svh"

module ctrl_regs
  import dnn_types_pkg::*;
  import dnn_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      reg_wr,
  input  logic      reg_rd,
  input  reg_addr_t reg_addr,
  input  word_t     reg_wdata,
  output word_t     reg_rdata,
  tile_cfg_if.regs  cfg,
  input  logic      pe_finish,
  input  acc_t      pe_result
);

  logic  busy;
  logic  done;
  acc_t  result_q;
  logic  cfg_wr;
  logic  go_acc;
  word_t rd_mux;

  // Setup frozen while a job runs
  assign cfg_wr = reg_wr && !busy;
  // Go bit is self clearing
  assign go_acc = cfg_wr && (reg_addr == `DNN_REG_CTRL) && reg_wdata[0];

  ////////////////////////////////////////
  // Configuration
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg.wght_base  <= '0;
      cfg.ifmap_base <= '0;
      cfg.len        <= tile_len_t'(1);
      cfg.relu_en    <= 1'b0;
    end else if (cfg_wr) begin
      case (reg_addr)
        `DNN_REG_CTRL:       cfg.relu_en    <= reg_wdata[1];
        `DNN_REG_WGHT_BASE:  cfg.wght_base  <= reg_wdata[`DNN_MEM_ADDR_W-1:0];
        `DNN_REG_IFMAP_BASE: cfg.ifmap_base <= reg_wdata[`DNN_MEM_ADDR_W-1:0];
        // Only 1..DEPTH is meaningful
        `DNN_REG_LEN:        cfg.len        <= reg_wdata[$bits(tile_len_t)-1:0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // Job status
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg.start <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
      result_q  <= '0;
    end else begin
      cfg.start <= go_acc;
      if (go_acc) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (pe_finish) begin
        // Finish only arrives during a job
        busy     <= 1'b0;
        done     <= 1'b1;
        result_q <= pe_result;
      end
    end
  end

  // Read mux, unused offsets return zero
  always_comb begin
    rd_mux = '0;
    case (reg_addr)
      `DNN_REG_CTRL:       rd_mux[1] = cfg.relu_en;
      `DNN_REG_WGHT_BASE:  rd_mux[`DNN_MEM_ADDR_W-1:0] = cfg.wght_base;
      `DNN_REG_IFMAP_BASE: rd_mux[`DNN_MEM_ADDR_W-1:0] = cfg.ifmap_base;
      `DNN_REG_LEN:        rd_mux[$bits(tile_len_t)-1:0] = cfg.len;
      `DNN_REG_STATUS:     rd_mux[1:0] = {done, busy};
      // Sign extend sum to full word
      `DNN_REG_RESULT: begin
        rd_mux = {{(`DNN_WORD_W-`DNN_ACC_W){result_q[`DNN_ACC_W-1]}}, result_q};
      end
      default: ;
    endcase
  end

  // Read data lands one cycle later and holds
  always_ff @(posedge clk) begin
    if (reset) begin
      reg_rdata <= '0;
    end else if (reg_rd) begin
      reg_rdata <= rd_mux;
    end
  end

endmodule

/* hdl/tile_cfg_if.sv */
`timescale 1ns/100ps

interface tile_cfg_if
  import dnn_types_pkg::*;
();

  // Tile setup, static while busy
  mem_addr_t wght_base;
  mem_addr_t ifmap_base;
  tile_len_t len;
  logic      relu_en;

  // Job events, one cycle each
  logic      start;
  logic      fetch_done;

  // Register file owns the setup
  modport regs (output wght_base, ifmap_base, len, relu_en, start);

  // Fetcher consumes setup, reports buffers full
  modport fetch (input wght_base, ifmap_base, len, start, output fetch_done);

  // PE only needs length and output mode
  modport pe (input len, relu_en, fetch_done);

endinterface

/* hdl/dnn_ctrl_pkg.sv */
`include "dnn_defines.svh"

package dnn_ctrl_pkg;

  // Host register offset
  typedef logic [`DNN_REG_ADDR_W-1:0] reg_addr_t;

  // Fetch sequencer
  // REQ holds mem_req high, RELEASE waits for ack to fall
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_RELEASE,
    FETCH_DONE
  } fetch_state_t;

  // PE issue sequencer
  typedef enum logic [1:0] {
    PE_IDLE,
    PE_RUN,
    PE_DRAIN
  } pe_state_t;

endpackage

/* hdl/dnn_types_pkg.sv */
`include "dnn_defines.svh"

package dnn_types_pkg;

  // One memory word, eight packed lanes
  typedef logic [`DNN_WORD_W-1:0] word_t;

  // Signed operand of one lane
  typedef logic signed [`DNN_LANE_W-1:0] lane_t;

  // Full product of two lanes
  typedef logic signed [2*`DNN_LANE_W-1:0] prod_t;

  // Running dot product
  typedef logic signed [`DNN_ACC_W-1:0] acc_t;

  // External memory word address
  typedef logic [`DNN_MEM_ADDR_W-1:0] mem_addr_t;

  // Index into a tile buffer
  typedef logic [$clog2(`DNN_BUF_DEPTH)-1:0] buf_addr_t;

  // Word count 1..DEPTH, one bit wider than the index
  typedef logic [$clog2(`DNN_BUF_DEPTH):0] tile_len_t;

endpackage

/* hdl/dnn_defines.svh */
`ifndef DNN_DEFINES_SVH
`define DNN_DEFINES_SVH

// Data path widths
`define DNN_WORD_W      64
`define DNN_LANES       8
`define DNN_LANE_W      8
`define DNN_MEM_ADDR_W  32
`define DNN_ACC_W       32

// Words per tile buffer
`define DNN_BUF_DEPTH   16

// Host register map
`define DNN_REG_ADDR_W      3
`define DNN_REG_CTRL        3'd0
`define DNN_REG_WGHT_BASE   3'd1
`define DNN_REG_IFMAP_BASE  3'd2
`define DNN_REG_LEN         3'd3
`define DNN_REG_STATUS      3'd4
`define DNN_REG_RESULT      3'd5

`endif
